/* controller.sv */
// Main decoder and control pipe; unknown opcodes decode to a bubble that writes nothing
`timescale 1ns/1ps

module controller (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [5:0]           opD,
	input  logic [5:0]           functD,
	input  logic                 equalD,
	input  logic                 stallE,
	input  logic                 flushE,
	input  logic                 stallM,
	output logic                 pcSrcD,
	output logic                 jumpD,
	output logic                 branchD,
	output vectorCpuPkg::ctrlExT ctrlE,
	output vectorCpuPkg::ctrlExT ctrlM,
	output vectorCpuPkg::ctrlExT ctrlW
);
	import vectorCpuPkg::*;

	ctrlExT ctrlD;
	aluOpT functOp;

	always_comb begin
		case (functT'(functD))
			fnSub:   functOp = aluSub;
			fnAnd:   functOp = aluAnd;
			fnOr:    functOp = aluOr;
			fnSlt:   functOp = aluSlt;
			default: functOp = aluAdd;
		endcase
	end

	always_comb begin
		ctrlD = '0;
		branchD = 1'b0;
		jumpD = 1'b0;
		case (opcodeT'(opD))
			opRType: begin
				ctrlD.aluOp = functOp;
				ctrlD.regDst = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			opVType: begin
				ctrlD.aluOp = functOp;
				ctrlD.regDst = 1'b1;
				ctrlD.vRegWrite = 1'b1;
				// vadds takes its second operand from scalar rt
				ctrlD.scalarOperand = (functT'(functD) == fnAdds);
			end
			opAddi: begin
				ctrlD.aluSrc = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			opLw: begin
				ctrlD.aluSrc = 1'b1;
				ctrlD.regWrite = 1'b1;
				ctrlD.memRead = 1'b1;
				ctrlD.memToReg = 1'b1;
			end
			opSw: begin
				ctrlD.aluSrc = 1'b1;
				ctrlD.memWrite = 1'b1;
			end
			opVlw: begin
				ctrlD.aluSrc = 1'b1;
				ctrlD.vRegWrite = 1'b1;
				ctrlD.memRead = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.vectorAccess = 1'b1;
			end
			opVsw: begin
				ctrlD.aluSrc = 1'b1;
				ctrlD.memWrite = 1'b1;
				ctrlD.vectorAccess = 1'b1;
			end
			opBeq:   branchD = 1'b1;
			opJ:     jumpD = 1'b1;
			default: ;
		endcase
	end

	assign pcSrcD = branchD & equalD;

	always_ff @(posedge clk) begin
		if (reset || flushE)
			ctrlE <= '0;
		else if (!stallE)
			ctrlE <= ctrlD;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ctrlM <= '0;
		else if (!stallM)
			ctrlM <= ctrlE;
	end

	// Bubble into Writeback while Memory waits
	always_ff @(posedge clk) begin
		if (reset || stallM)
			ctrlW <= '0;
		else
			ctrlW <= ctrlM;
	end

endmodule

/* datapath.sv */
// Five-stage datapath; scalar lw zero-extends its halfword and register 0 ignores writes
`timescale 1ns/1ps

module datapath #(
	parameter logic [31:0] ResetPc = 32'h0000_0000
) (
	input  logic                                 clk,
	input  logic                                 reset,
	output logic [31:0]                          pcF,
	input  logic [31:0]                          instrF,
	output logic [5:0]                           opD,
	output logic [5:0]                           functD,
	output logic                                 equalD,
	input  logic                                 pcSrcD,
	input  logic                                 jumpD,
	input  vectorCpuPkg::ctrlExT                 ctrlE,
	input  vectorCpuPkg::ctrlExT                 ctrlW,
	output logic [4:0]                           rsD,
	output logic [4:0]                           rtD,
	output logic [4:0]                           rsE,
	output logic [4:0]                           rtE,
	output logic [4:0]                           writeRegE,
	output logic [4:0]                           writeRegM,
	output logic [4:0]                           writeRegW,
	input  logic                                 forwardAD,
	input  logic                                 forwardBD,
	input  logic [1:0]                           forwardAE,
	input  logic [1:0]                           forwardBE,
	input  logic [1:0]                           vForwardAE,
	input  logic [1:0]                           vForwardBE,
	input  logic                                 stallF,
	input  logic                                 stallD,
	input  logic                                 stallE,
	input  logic                                 stallM,
	input  logic                                 flushE,
	output logic [31:0]                          aluOutM,
	output logic [vectorCpuPkg::LaneWidth-1:0]   writeHalfM,
	output logic [vectorCpuPkg::VectorWidth-1:0] vWriteDataM,
	input  logic [vectorCpuPkg::LaneWidth-1:0]   readHalfM,
	input  logic [vectorCpuPkg::VectorWidth-1:0] readVectorM
);
	import vectorCpuPkg::*;

	logic [31:0] pcNextF, pcPlus4F;
	logic [31:0] instrD, pcPlus4D, signImmD, pcBranchD;
	logic [31:0] srcAD, srcBD, srcA2D, srcB2D;
	logic [VectorWidth-1:0] vSrcAD, vSrcBD;
	logic [4:0] rdD, rdE;
	logic flushD;
	logic [31:0] srcAE, srcBE, signImmE, srcA2E, srcB2E, srcB3E, aluOutE;
	logic [VectorWidth-1:0] vSrcAE, vSrcBE, vSrcA2E, vSrcB2E, vAluOutE, vAluOutM;
	logic [31:0] aluOutW, readDataW, resultW;
	logic [VectorWidth-1:0] vAluOutW, vReadDataW, vResultW;
	logic [31:0] rf [32];
	logic [VectorWidth-1:0] vrf [32];

	// Fetch
	assign pcPlus4F = pcF + 32'd4;
	assign pcNextF = jumpD ? {pcPlus4D[31:28], instrD[25:0], 2'b00} :
		pcSrcD ? pcBranchD : pcPlus4F;

	always_ff @(posedge clk) begin
		if (reset)
			pcF <= ResetPc;
		else if (!stallF)
			pcF <= pcNextF;
	end

	// Decode
	assign flushD = (pcSrcD | jumpD) & ~stallD;

	always_ff @(posedge clk) begin
		if (reset || flushD)
			instrD <= '0;
		else if (!stallD)
			instrD <= instrF;
	end

	always_ff @(posedge clk) begin
		if (!stallD)
			pcPlus4D <= pcPlus4F;
	end

	assign opD = instrD[31:26];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign functD = instrD[5:0];
	assign signImmD = {{16{instrD[15]}}, instrD[15:0]};
	assign pcBranchD = pcPlus4D + {signImmD[29:0], 2'b00};

	// Both files write at the edge, reads bypass the Writeback value
	always_ff @(posedge clk) begin
		if (ctrlW.regWrite && writeRegW != 5'd0)
			rf[writeRegW] <= resultW;
		if (ctrlW.vRegWrite && writeRegW != 5'd0)
			vrf[writeRegW] <= vResultW;
	end

	assign srcAD = (rsD == 5'd0) ? '0 : (ctrlW.regWrite && rsD == writeRegW) ? resultW : rf[rsD];
	assign srcBD = (rtD == 5'd0) ? '0 : (ctrlW.regWrite && rtD == writeRegW) ? resultW : rf[rtD];
	assign vSrcAD = (rsD == 5'd0) ? '0 :
		(ctrlW.vRegWrite && rsD == writeRegW) ? vResultW : vrf[rsD];
	assign vSrcBD = (rtD == 5'd0) ? '0 :
		(ctrlW.vRegWrite && rtD == writeRegW) ? vResultW : vrf[rtD];

	assign srcA2D = forwardAD ? aluOutM : srcAD;
	assign srcB2D = forwardBD ? aluOutM : srcBD;
	assign equalD = (srcA2D == srcB2D);

	// Execute
	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			rsE <= '0;
			rtE <= '0;
			rdE <= '0;
		end else if (!stallE) begin
			rsE <= rsD;
			rtE <= rtD;
			rdE <= rdD;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			srcAE <= srcAD;
			srcBE <= srcBD;
			vSrcAE <= vSrcAD;
			vSrcBE <= vSrcBD;
			signImmE <= signImmD;
		end else begin
			// Frozen operands keep the forwarded value, Writeback drains meanwhile
			srcAE <= srcA2E;
			srcBE <= srcB2E;
			vSrcAE <= vSrcA2E;
			vSrcBE <= vSrcB2E;
		end
	end

	assign srcA2E = forwardAE[1] ? aluOutM : forwardAE[0] ? resultW : srcAE;
	assign srcB2E = forwardBE[1] ? aluOutM : forwardBE[0] ? resultW : srcBE;
	assign vSrcA2E = vForwardAE[1] ? vAluOutM : vForwardAE[0] ? vResultW : vSrcAE;
	assign vSrcB2E = vForwardBE[1] ? vAluOutM : vForwardBE[0] ? vResultW : vSrcBE;
	assign srcB3E = ctrlE.aluSrc ? signImmE : srcB2E;
	assign writeRegE = ctrlE.regDst ? rdE : rtE;

	executeUnit u_executeUnit (
		.srcA          (srcA2E),
		.srcB          (srcB3E),
		.vSrcA         (vSrcA2E),
		.vSrcB         (vSrcB2E),
		.aluOp         (ctrlE.aluOp),
		.scalarOperand (ctrlE.scalarOperand),
		.aluOut        (aluOutE),
		.vAluOut       (vAluOutE)
	);

	// Memory
	always_ff @(posedge clk) begin
		if (!stallM) begin
			aluOutM <= aluOutE;
			writeHalfM <= srcB2E[LaneWidth-1:0];
			vWriteDataM <= vSrcB2E;
			vAluOutM <= vAluOutE;
			writeRegM <= writeRegE;
		end
	end

	// Writeback
	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		readDataW <= 32'(readHalfM);
		writeRegW <= writeRegM;
		vAluOutW <= vAluOutM;
		vReadDataW <= readVectorM;
	end

	assign resultW = ctrlW.memToReg ? readDataW : aluOutW;
	assign vResultW = ctrlW.memToReg ? vReadDataW : vAluOutW;

endmodule

/* executeUnit.sv */
// Scalar ALU and lane ALU; lane slt compares signed halfwords and results wrap at 16 bits
`timescale 1ns/1ps

module executeUnit (
	input  logic [31:0]                           srcA,
	input  logic [31:0]                           srcB,
	input  logic [vectorCpuPkg::VectorWidth-1:0]  vSrcA,
	input  logic [vectorCpuPkg::VectorWidth-1:0]  vSrcB,
	input  vectorCpuPkg::aluOpT                   aluOp,
	input  logic                                  scalarOperand,
	output logic [31:0]                           aluOut,
	output logic [vectorCpuPkg::VectorWidth-1:0]  vAluOut
);
	import vectorCpuPkg::*;

	function automatic logic [31:0] aluCalc(input logic [31:0] a, input logic [31:0] b,
			input aluOpT op);
		case (op)
			aluSub:  return a - b;
			aluAnd:  return a & b;
			aluOr:   return a | b;
			aluSlt:  return {31'd0, $signed(a) < $signed(b)};
			default: return a + b;
		endcase
	endfunction

	assign aluOut = aluCalc(srcA, srcB, aluOp);

	always_comb begin : laneAlu
		logic [LaneWidth-1:0] laneA;
		logic [LaneWidth-1:0] laneB;
		logic [31:0] laneResult;
		for (int i = 0; i < LaneCount; i++) begin
			laneA = vSrcA[i*LaneWidth +: LaneWidth];
			// Broadcast the low halfword for vadds
			laneB = scalarOperand ? srcB[LaneWidth-1:0] : vSrcB[i*LaneWidth +: LaneWidth];
			// Sign extension keeps slt correct per lane
			laneResult = aluCalc({{(32-LaneWidth){laneA[LaneWidth-1]}}, laneA},
				{{(32-LaneWidth){laneB[LaneWidth-1]}}, laneB}, aluOp);
			vAluOut[i*LaneWidth +: LaneWidth] = laneResult[LaneWidth-1:0];
		end
	end

endmodule

/* hazardUnit.sv */
// Forwarding and stall control; load-use detection compares register numbers across both files
`timescale 1ns/1ps

module hazardUnit (
	input  logic [4:0]           rsD,
	input  logic [4:0]           rtD,
	input  logic [4:0]           rsE,
	input  logic [4:0]           rtE,
	input  logic [4:0]           writeRegE,
	input  logic [4:0]           writeRegM,
	input  logic [4:0]           writeRegW,
	input  vectorCpuPkg::ctrlExT ctrlE,
	input  vectorCpuPkg::ctrlExT ctrlM,
	input  vectorCpuPkg::ctrlExT ctrlW,
	input  logic                 branchD,
	input  logic                 busy,
	output logic                 forwardAD,
	output logic                 forwardBD,
	output logic [1:0]           forwardAE,
	output logic [1:0]           forwardBE,
	output logic [1:0]           vForwardAE,
	output logic [1:0]           vForwardBE,
	output logic                 stallF,
	output logic                 stallD,
	output logic                 stallE,
	output logic                 stallM,
	output logic                 flushE
);

	logic scalarWriteM;
	logic vectorWriteM;
	logic lwStall;
	logic branchStall;

	// 2'b10 from Memory, 2'b01 from Writeback
	function automatic logic [1:0] forwardSel(input logic [4:0] src, input logic writeM,
			input logic [4:0] regM, input logic writeW, input logic [4:0] regW);
		if (src != 5'd0 && writeM && src == regM)
			return 2'b10;
		else if (src != 5'd0 && writeW && src == regW)
			return 2'b01;
		return 2'b00;
	endfunction

	// A load in Memory only holds its address
	assign scalarWriteM = ctrlM.regWrite && !ctrlM.memToReg;
	assign vectorWriteM = ctrlM.vRegWrite && !ctrlM.memToReg;

	assign forwardAE = forwardSel(rsE, scalarWriteM, writeRegM, ctrlW.regWrite, writeRegW);
	assign forwardBE = forwardSel(rtE, scalarWriteM, writeRegM, ctrlW.regWrite, writeRegW);
	assign vForwardAE = forwardSel(rsE, vectorWriteM, writeRegM, ctrlW.vRegWrite, writeRegW);
	assign vForwardBE = forwardSel(rtE, vectorWriteM, writeRegM, ctrlW.vRegWrite, writeRegW);

	assign forwardAD = rsD != 5'd0 && rsD == writeRegM && scalarWriteM;
	assign forwardBD = rtD != 5'd0 && rtD == writeRegM && scalarWriteM;

	assign lwStall = ctrlE.memToReg && (writeRegE == rsD || writeRegE == rtD);
	assign branchStall = branchD &&
		((ctrlE.regWrite && (writeRegE == rsD || writeRegE == rtD)) ||
		(ctrlM.regWrite && ctrlM.memToReg && (writeRegM == rsD || writeRegM == rtD)));

	assign stallD = lwStall || branchStall || busy;
	assign stallF = stallD;
	assign stallE = busy;
	assign stallM = busy;
	assign flushE = (lwStall || branchStall) && !busy;

endmodule

/* project.f */
vectorCpuPkg.sv
controller.sv
hazardUnit.sv
executeUnit.sv
vectorLoadStoreUnit.sv
datapath.sv
vectorCpu.sv
tbClock.sv
vectorCpu_asserts.sv
vectorCpuTb.sv

/* tbClock.sv */
// Free-running 10 ns clock and a synchronous reset held for the first 3 rising edges
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

/* vectorCpu.sv */
// Core top; instruction fetch is a combinational read and data memory must return credits
`timescale 1ns/1ps

module vectorCpu #(
	parameter logic [31:0] ResetPc = 32'h0000_0000,
	parameter int MemCredits = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	output logic [31:0]           pcF,
	input  logic [31:0]           instrF,
	output vectorCpuPkg::memReqT  memReq,
	output logic                  reqValid,
	input  logic                  creditReturn,
	input  vectorCpuPkg::memRespT memResp,
	input  logic                  respValid
);
	import vectorCpuPkg::*;

	logic [5:0] opD, functD;
	logic equalD, pcSrcD, jumpD, branchD;
	ctrlExT ctrlE, ctrlM, ctrlW;
	logic [4:0] rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW;
	logic forwardAD, forwardBD;
	logic [1:0] forwardAE, forwardBE, vForwardAE, vForwardBE;
	logic stallF, stallD, stallE, stallM, flushE, busy;
	logic [31:0] aluOutM;
	logic [LaneWidth-1:0] writeHalfM, readHalfM;
	logic [VectorWidth-1:0] vWriteDataM, readVectorM;

	controller u_controller (.*);

	hazardUnit u_hazardUnit (.*);

	datapath #(.ResetPc(ResetPc)) u_datapath (.*);

	vectorLoadStoreUnit #(.MemCredits(MemCredits)) u_vectorLoadStoreUnit (
		.clk          (clk),
		.reset        (reset),
		.memRead      (ctrlM.memRead),
		.memWrite     (ctrlM.memWrite),
		.vectorAccess (ctrlM.vectorAccess),
		.address      (aluOutM),
		.scalarData   (writeHalfM),
		.vectorData   (vWriteDataM),
		.busy         (busy),
		.readHalf     (readHalfM),
		.readVector   (readVectorM),
		.memReq       (memReq),
		.reqValid     (reqValid),
		.creditReturn (creditReturn),
		.memResp      (memResp),
		.respValid    (respValid)
	);

endmodule

/* vectorCpuPkg.sv */
// Shared types for the vector core; the lane count is fixed since the instruction encoding assumes it
package vectorCpuPkg;

	localparam int LaneCount = 16;
	localparam int LaneWidth = 16;
	localparam int VectorWidth = LaneCount * LaneWidth;

	// Major opcodes in instr[31:26]
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opVType = 6'h1c,
		opLw    = 6'h23,
		opSw    = 6'h2b,
		opVlw   = 6'h33,
		opVsw   = 6'h3b
	} opcodeT;

	// Function field of R and V types, fnAdds only valid for V type
	typedef enum logic [5:0] {
		fnAdd  = 6'h20,
		fnSub  = 6'h22,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a,
		fnAdds = 6'h30
	} functT;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrc;
		logic  regDst;
		logic  scalarOperand;
		logic  regWrite;
		logic  vRegWrite;
		logic  memRead;
		logic  memWrite;
		logic  vectorAccess;
		logic  memToReg;
	} ctrlExT;

	// One memory line request, address is line aligned
	typedef struct packed {
		logic [31:0]              address;
		logic                     write;
		logic [VectorWidth/8-1:0] byteEnable;
		logic [VectorWidth-1:0]   writeData;
	} memReqT;

	typedef struct packed {
		logic [VectorWidth-1:0] readData;
	} memRespT;

endpackage

/* vectorCpuTb.sv */
// Program ROM at address 0 and a 16-line data memory; addresses above 511 alias onto it
`timescale 1ns/1ps

module vectorCpuTb;
	import vectorCpuPkg::*;

	localparam int MemCredits = 4;
	localparam int ProgramLength = 41;
	localparam int TimeoutCycles = 40 * ProgramLength + 200;

	logic clk;
	logic reset;
	logic [31:0] pcF;
	logic [31:0] instrF;
	memReqT memReq;
	logic reqValid;
	logic creditReturn;
	memRespT memResp;
	logic respValid;

	logic [31:0] rom [64];
	logic [VectorWidth-1:0] mem [16];
	integer seed;
	int cycle;
	int storesSeen;
	int creditDue [$];
	int respDue [$];
	logic [VectorWidth-1:0] respData [$];
	logic [31:0] expAddr [$];
	logic [31:0] expBe [$];
	logic [VectorWidth-1:0] expData [$];

	tbClock u_tbClock (.clk(clk), .reset(reset));

	vectorCpu #(.ResetPc(32'h0000_0000), .MemCredits(MemCredits)) i_dut (
		.clk          (clk),
		.reset        (reset),
		.pcF          (pcF),
		.instrF       (instrF),
		.memReq       (memReq),
		.reqValid     (reqValid),
		.creditReturn (creditReturn),
		.memResp      (memResp),
		.respValid    (respValid)
	);

	// Combinational instruction ROM
	assign instrF = rom[pcF[7:2]];

	function automatic logic [31:0] encodeR(logic [5:0] op, int rs, int rt, int rd,
			logic [5:0] funct);
		return {op, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] encodeJ(int target);
		return {opJ, 26'(target)};
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < 64; i++)
			rom[i] = '0;
		rom[0] = encodeI(opAddi, 0, 10, 256);
		rom[1] = encodeI(opAddi, 0, 1, 100);
		rom[2] = encodeI(opAddi, 0, 2, -7);
		// Back-to-back dependencies
		rom[3] = encodeR(opRType, 1, 2, 3, fnAdd);
		rom[4] = encodeR(opRType, 3, 1, 4, fnSub);
		rom[5] = encodeR(opRType, 4, 3, 5, fnSlt);
		rom[6] = encodeR(opRType, 3, 1, 6, fnAnd);
		rom[7] = encodeR(opRType, 6, 2, 7, fnOr);
		rom[8] = encodeI(opSw, 10, 3, 0);
		rom[9] = encodeI(opSw, 10, 4, 2);
		rom[10] = encodeI(opSw, 10, 5, 4);
		rom[11] = encodeI(opSw, 10, 7, 6);
		// Load-use, then a branch on a fresh register
		rom[12] = encodeI(opLw, 0, 8, 34);
		rom[13] = encodeR(opRType, 8, 1, 9, fnAdd);
		rom[14] = encodeI(opSw, 10, 9, 8);
		rom[15] = encodeI(opAddi, 8, 11, 0);
		rom[16] = encodeI(opBeq, 11, 8, 1);
		rom[17] = encodeI(opSw, 10, 1, 10);
		rom[18] = encodeI(opSw, 10, 11, 12);
		rom[19] = encodeJ(21);
		rom[20] = encodeI(opSw, 10, 2, 14);
		// Odd lane store and read back
		rom[21] = encodeI(opAddi, 0, 12, 16'h1234);
		rom[22] = encodeI(opSw, 10, 12, 42);
		rom[23] = encodeI(opLw, 10, 13, 42);
		rom[24] = encodeI(opSw, 10, 13, 16);
		rom[25] = encodeI(opVlw, 0, 1, 64);
		rom[26] = encodeI(opVlw, 0, 2, 96);
		rom[27] = encodeR(opVType, 1, 2, 3, fnAdd);
		rom[28] = encodeR(opVType, 1, 2, 4, fnSub);
		rom[29] = encodeR(opVType, 3, 4, 5, fnAnd);
		rom[30] = encodeR(opVType, 5, 1, 6, fnOr);
		rom[31] = encodeR(opVType, 6, 1, 7, fnAdds);
		rom[32] = encodeI(opVsw, 0, 3, 128);
		rom[33] = encodeI(opVsw, 0, 4, 160);
		rom[34] = encodeI(opVsw, 0, 5, 192);
		rom[35] = encodeI(opVsw, 0, 6, 224);
		rom[36] = encodeI(opVsw, 0, 7, 320);
		rom[37] = encodeI(opVlw, 0, 8, 128);
		rom[38] = encodeR(opVType, 8, 8, 9, fnAdd);
		rom[39] = encodeI(opVsw, 0, 9, 352);
		rom[40] = encodeJ(40);
	endtask

	function automatic logic [31:0] aluRef(logic [5:0] funct, logic [31:0] a, logic [31:0] b);
		case (funct)
			fnSub:   return a - b;
			fnAnd:   return a & b;
			fnOr:    return a | b;
			fnSlt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	// Runs the program on a register and memory model, queueing each store it makes
	function automatic void buildExpectedStores();
		logic [31:0] r [32];
		logic [VectorWidth-1:0] v [32];
		logic [VectorWidth-1:0] m [16];
		logic [VectorWidth-1:0] res;
		logic [31:0] pc, instr, a, b, imm, addr, laneOut;
		logic [5:0] op, funct;
		logic [4:0] rs, rt, rd;
		logic [15:0] lb;
		int line, lane;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
			v[i] = '0;
		end
		for (int i = 0; i < 16; i++)
			m[i] = mem[i];
		pc = '0;
		for (int step = 0; step < 200; step++) begin
			instr = rom[pc[7:2]];
			op = instr[31:26];
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			funct = instr[5:0];
			a = r[rs];
			b = r[rt];
			imm = {{16{instr[15]}}, instr[15:0]};
			addr = a + imm;
			line = addr[8:5];
			lane = addr[4:1];
			pc = pc + 32'd4;
			if (op == opJ && {pc[31:28], instr[25:0], 2'b00} == pc - 32'd4)
				break;
			case (op)
				opRType: if (rd != 0) r[rd] = aluRef(funct, a, b);
				opVType: begin
					for (int i = 0; i < LaneCount; i++) begin
						lb = (funct == fnAdds) ? b[15:0] : v[rt][i*16 +: 16];
						laneOut = aluRef(funct == fnAdds ? fnAdd : funct,
							{16'd0, v[rs][i*16 +: 16]}, {16'd0, lb});
						res[i*16 +: 16] = laneOut[15:0];
					end
					if (rd != 0) v[rd] = res;
				end
				opAddi: if (rt != 0) r[rt] = addr;
				opLw: if (rt != 0) r[rt] = {16'd0, m[line][lane*16 +: 16]};
				opSw: begin
					m[line][lane*16 +: 16] = b[15:0];
					expAddr.push_back(addr & ~32'd31);
					expBe.push_back(32'h3 << (lane * 2));
					expData.push_back(VectorWidth'(b[15:0]) << (lane * 16));
				end
				opVlw: if (rt != 0) v[rt] = m[line];
				opVsw: begin
					m[line] = v[rt];
					expAddr.push_back(addr & ~32'd31);
					expBe.push_back('1);
					expData.push_back(v[rt]);
				end
				opBeq: if (a == b) pc = pc + (imm << 2);
				opJ: pc = {pc[31:28], instr[25:0], 2'b00};
				default: ;
			endcase
		end
	endfunction

	function automatic bit creditsWithheld(int c);
		return (c >= 20 && c < 50) || (c >= 120 && c < 150);
	endfunction

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(input string name, input logic [VectorWidth-1:0] actual,
			input logic [VectorWidth-1:0] expected);
		if (actual !== expected)
			reportFailure($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
	endtask

	// Memory model with random credit and response delay
	always @(posedge clk) begin : memoryModel
		int line;
		cycle++;
		if (!reset && reqValid) begin
			line = memReq.address[8:5];
			if (memReq.write) begin
				for (int i = 0; i < VectorWidth / 8; i++)
					if (memReq.byteEnable[i])
						mem[line][i*8 +: 8] = memReq.writeData[i*8 +: 8];
			end else begin
				respDue.push_back(cycle + 1 + {$random(seed)} % 4);
				respData.push_back(mem[line]);
			end
			creditDue.push_back(cycle + 1 + {$random(seed)} % 4);
		end
		#1;
		creditReturn = 1'b0;
		respValid = 1'b0;
		if (creditDue.size() > 0 && creditDue[0] <= cycle && !creditsWithheld(cycle)) begin
			creditReturn = 1'b1;
			void'(creditDue.pop_front());
		end
		if (respDue.size() > 0 && respDue[0] <= cycle) begin
			respValid = 1'b1;
			memResp.readData = respData.pop_front();
			void'(respDue.pop_front());
		end
	end

	always @(posedge clk) begin : storeCompare
		logic [VectorWidth-1:0] mask;
		if (!reset && reqValid && memReq.write) begin
			if (expAddr.size() == 0) begin
				reportFailure("a store appeared after all expected stores were seen");
			end else begin
				for (int i = 0; i < VectorWidth / 8; i++)
					mask[i*8 +: 8] = {8{expBe[0][i]}};
				checkValue("memReq.address", memReq.address, expAddr[0]);
				checkValue("memReq.byteEnable", memReq.byteEnable, expBe[0]);
				checkValue("memReq.writeData", memReq.writeData & mask, expData[0] & mask);
				void'(expAddr.pop_front());
				void'(expBe.pop_front());
				void'(expData.pop_front());
				storesSeen++;
			end
		end
	end

	// Credit protocol assertions in the load-store unit
	always @(posedge clk) begin : assertionMonitor
		if (i_dut.u_vectorLoadStoreUnit.u_vectorCpuAsserts.failures != 0)
			reportFailure("a credit protocol assertion failed");
	end

	initial begin : watchdog
		repeat (TimeoutCycles) @(posedge clk);
		reportFailure($sformatf("the run timed out after %0d cycles with %0d stores seen",
			TimeoutCycles, storesSeen));
	end

	initial begin
		int expectedTotal;
		creditReturn = 1'b0;
		respValid = 1'b0;
		memResp = '0;
		seed = 36;
		cycle = 0;
		storesSeen = 0;
		for (int i = 0; i < 16; i++)
			for (int w = 0; w < VectorWidth / 32; w++)
				mem[i][w*32 +: 32] = $random(seed);
		loadProgram();
		buildExpectedStores();
		expectedTotal = expAddr.size();
		wait (!reset);
		wait (storesSeen == expectedTotal);
		// Let any stray store show up
		repeat (20) @(posedge clk);
		@(negedge clk);
		if (i_dut.u_vectorLoadStoreUnit.u_vectorCpuAsserts.failures == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			reportFailure("a credit protocol assertion failed");
		end
	end

endmodule

/* vectorCpu_asserts.sv */
// Credit protocol checks on the load-store unit; assumes one returned credit per cycle at most
`timescale 1ns/1ps

module vectorCpuAsserts #(
	parameter int MemCredits = 4
) (
	input logic                               clk,
	input logic                               reset,
	input logic                               reqValid,
	input logic                               busy,
	input logic                               creditReturn,
	input logic [$clog2(MemCredits + 1)-1:0]  credits
);

	int failures = 0;
	int available;

	// Credit count rebuilt from the request and return pulses
	always_ff @(posedge clk) begin
		if (reset)
			available <= MemCredits;
		else
			available <= available - int'(reqValid) + int'(creditReturn);
	end

	noRequestWithoutCredit: assert property (@(posedge clk) disable iff (reset)
		reqValid |-> available > 0)
		else begin
			$error("request raised with zero credits");
			failures++;
		end

	quietAfterReset: assert property (@(posedge clk) reset |=> (!reqValid && !busy))
		else begin
			$error("reqValid or busy high after reset");
			failures++;
		end

	creditsBounded: assert property (@(posedge clk) disable iff (reset)
		credits <= MemCredits)
		else begin
			$error("credit count above its maximum");
			failures++;
		end

	// A credit can only come back for a request still outstanding
	noSpareCredit: assert property (@(posedge clk) disable iff (reset)
		creditReturn |-> credits < MemCredits)
		else begin
			$error("credit returned with no request outstanding");
			failures++;
		end

endmodule

bind vectorLoadStoreUnit vectorCpuAsserts #(.MemCredits(MemCredits)) u_vectorCpuAsserts (
	.clk          (clk),
	.reset        (reset),
	.reqValid     (reqValid),
	.busy         (busy),
	.creditReturn (creditReturn),
	.credits      (credits)
);

/* vectorLoadStoreUnit.sv */
// Memory-stage access unit; one load outstanding at a time, responses must come back in order
`timescale 1ns/1ps

module vectorLoadStoreUnit #(
	parameter int MemCredits = 4
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 memRead,
	input  logic                                 memWrite,
	input  logic                                 vectorAccess,
	input  logic [31:0]                          address,
	input  logic [vectorCpuPkg::LaneWidth-1:0]   scalarData,
	input  logic [vectorCpuPkg::VectorWidth-1:0] vectorData,
	output logic                                 busy,
	output logic [vectorCpuPkg::LaneWidth-1:0]   readHalf,
	output logic [vectorCpuPkg::VectorWidth-1:0] readVector,
	output vectorCpuPkg::memReqT                 memReq,
	output logic                                 reqValid,
	input  logic                                 creditReturn,
	input  vectorCpuPkg::memRespT                memResp,
	input  logic                                 respValid
);
	import vectorCpuPkg::*;

	localparam int CreditWidth = $clog2(MemCredits + 1);
	localparam int LaneIndexWidth = $clog2(LaneCount);
	localparam int LineOffsetWidth = $clog2(VectorWidth / 8);

	typedef enum logic {
		idle,
		waitResp
	} lsuStateT;

	lsuStateT state;
	logic [CreditWidth-1:0] credits;
	logic [LaneIndexWidth-1:0] laneSel;

	// Halfword lane within the line
	assign laneSel = address[LaneIndexWidth:1];

	assign reqValid = (memRead || memWrite) && state == idle && credits != '0;

	// Loads wait for data, stores only for a credit
	assign busy = (memRead && !(state == waitResp && respValid)) ||
		(memWrite && credits == '0);

	always_comb begin
		memReq.address = {address[31:LineOffsetWidth], {LineOffsetWidth{1'b0}}};
		memReq.write = memWrite;
		if (vectorAccess) begin
			memReq.byteEnable = '1;
			memReq.writeData = vectorData;
		end else begin
			memReq.byteEnable = (VectorWidth/8)'(2'b11) << {laneSel, 1'b0};
			memReq.writeData = {LaneCount{scalarData}};
		end
	end

	assign readVector = memResp.readData;
	assign readHalf = memResp.readData[laneSel*LaneWidth +: LaneWidth];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle:     if (reqValid && memRead) state <= waitResp;
				waitResp: if (respValid) state <= idle;
				default:  state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			credits <= CreditWidth'(MemCredits);
		else
			credits <= credits - CreditWidth'(reqValid) + CreditWidth'(creditReturn);
	end

endmodule
